//--- clk_mgmt_top.f
+incdir+hw
hw/clk_mgmt_pkg.sv
hw/req_filter.sv
hw/pll_reconfig_fsm.sv
hw/grav_clock_gen.sv
hw/clk_mgmt_top.sv
bench/clk_mgmt_chk.sv
bench/clk_mgmt_tb.sv

//--- run_sim.sh
#!/bin/sh
# Compile the clock management testbench with Verilator and run it
cd "$(dirname "$0")" &&
verilator --binary --timing --assert --top-module clk_mgmt_tb \
	-f clk_mgmt_top.f -o clk_mgmt_sim &&
./obj_dir/clk_mgmt_sim &&
echo "run_sim: simulation passed" ||
{ echo "run_sim: build or simulation failed"; exit 1; }

//--- bench/clk_mgmt_tb.sv
// Clock management testbench
// Changes speed and UART requests, adds back-pressure and lock drops,
// checks every PLL configuration write and counts gameport toggles

`include "clk_mgmt_defines.svh"

module clk_mgmt_tb;

	logic                      clk_sys = 1'b0;
	logic                      reset = 1'b1;
	logic                      pll_locked = 1'b0;
	logic                      cfg_waitrequest = 1'b0;
	clk_mgmt_pkg::cpu_speed_t  speed_req = 3'd0;
	clk_mgmt_pkg::uart_rate_t  uart_req = clk_mgmt_pkg::UART_NORMAL;
	clk_mgmt_pkg::pll_cfg_wr_t pll_cfg;
	logic                      grav_clk;

	// Model of the requests the DUT should currently be serving
	clk_mgmt_pkg::cpu_speed_t  exp_speed = 3'd0;
	clk_mgmt_pkg::uart_rate_t  exp_uart = clk_mgmt_pkg::UART_NORMAL;
	string                     test_name = "reset_sequence";
	logic                      busy_en = 1'b0;
	logic [31:0]               rng = 32'h01c0abd7;
	logic [31:0]               wait_rng = 32'h01c0abd7;
	int                        wr_pos = 0;
	int                        seq_count = 0;
	int                        write_count = 0;
	int                        toggle_count = 0;
	logic                      grav_prev = 1'b0;

	always #20 clk_sys = ~clk_sys;

	clk_mgmt_top UUT (
		.clk_sys         (clk_sys),
		.reset           (reset),
		.pll_locked      (pll_locked),
		.cfg_waitrequest (cfg_waitrequest),
		.speed_req       (speed_req),
		.uart_req        (uart_req),
		.pll_cfg         (pll_cfg),
		.grav_clk        (grav_clk)
	);

	// ------------------------------------------------------------------
	// Reference model
	// ------------------------------------------------------------------

	function automatic logic [31:0] xorshift32(input logic [31:0] x);
		logic [31:0] y;
		y = x ^ (x << 13);
		y = y ^ (y >> 17);
		y = y ^ (y << 5);
		return y;
	endfunction

	function automatic clk_mgmt_pkg::pll_cfg_wr_t expected_word(input int pos,
			input clk_mgmt_pkg::cpu_speed_t spd, input clk_mgmt_pkg::uart_rate_t ur);
		clk_mgmt_pkg::pll_cfg_wr_t w;
		w.write   = 1'b1;
		w.address = `CFG_ADDR_CDIV;
		w.data    = 32'd0;
		if (pos == 0) begin
			w.address = `CFG_ADDR_MODE;
		end else if (pos == 1) begin
			case (spd)
				3'd0:    w.data = 32'h00505;
				3'd1:    w.data = 32'h01e1e;
				3'd2:    w.data = 32'h00f0f;
				3'd3:    w.data = 32'h00808;
				default: w.data = 32'h20504;
			endcase
		end else if (pos == 2) begin
			case (ur)
				clk_mgmt_pkg::UART_FAST:   w.data = 32'h40909;
				clk_mgmt_pkg::UART_NORMAL: w.data = 32'h4f4f4;
				default:                   w.data = 32'h49696;
			endcase
		end else begin
			w.address = `CFG_ADDR_START;
		end
		return w;
	endfunction

	// Toggles expected over a window, step times cycles over the CPU rate
	function automatic int expected_toggles(input clk_mgmt_pkg::cpu_speed_t code,
			input int cycles);
		longint rate;
		case (code)
			3'd0:    rate = 64'd90000000;
			3'd1:    rate = 64'd15000000;
			3'd2:    rate = 64'd30000000;
			3'd3:    rate = 64'd56250000;
			default: rate = 64'd100000000;
		endcase
		return int'((longint'(cycles) * longint'(`GRAV_STEP)) / rate);
	endfunction

	task automatic abort_run();
		$display("Simulation finished: FAIL");
		$fatal(1, "run stopped at the first error");
	endtask

	task automatic check_cfg(input string name, input clk_mgmt_pkg::pll_cfg_wr_t expected,
			input clk_mgmt_pkg::pll_cfg_wr_t actual);
		if (actual !== expected) begin
			$display("Error %s: expected addr %0d data %h, actual write %b addr %0d data %h",
				name, expected.address, expected.data, actual.write, actual.address,
				actual.data);
			abort_run();
		end
	endtask

	task automatic check_toggles(input string name, input int expected, input int actual);
		if (actual > expected + 1 || actual < expected - 1) begin
			$display("Error %s: expected %0d toggles, actual %0d", name, expected, actual);
			abort_run();
		end
	endtask

	task automatic check_count(input string name, input int expected, input int actual);
		if (actual != expected) begin
			$display("Error %s: expected count %0d, actual %0d", name, expected, actual);
			abort_run();
		end
	endtask

	// Drive new requests, wait for their write sequence, then hold them
	task automatic change_request(input clk_mgmt_pkg::cpu_speed_t spd,
			input clk_mgmt_pkg::uart_rate_t ur, input int limit);
		int target;
		int cycles;
		target = seq_count + 1;
		cycles = 0;
		@(negedge clk_sys);
		exp_speed = spd;
		exp_uart  = ur;
		speed_req = spd;
		uart_req  = ur;
		while (seq_count < target) begin
			@(negedge clk_sys);
			cycles++;
			if (cycles > limit) begin
				$display("Timed out in %s waiting for a PLL write sequence", test_name);
				abort_run();
			end
		end
		while (cycles < limit) begin
			@(negedge clk_sys);
			cycles++;
		end
		check_count(test_name, target, seq_count);
	endtask

	// ------------------------------------------------------------------
	// Monitors
	// ------------------------------------------------------------------

	always @(posedge clk_sys) begin
		if (!reset && pll_cfg.write && !cfg_waitrequest) begin
			check_cfg(test_name, expected_word(wr_pos, exp_speed, exp_uart), pll_cfg);
			write_count <= write_count + 1;
			if (wr_pos == 3) begin
				wr_pos    <= 0;
				seq_count <= seq_count + 1;
			end else begin
				wr_pos <= wr_pos + 1;
			end
		end
	end

	always @(posedge clk_sys) begin
		grav_prev <= grav_clk;
		if (!reset && grav_clk != grav_prev) begin
			toggle_count <= toggle_count + 1;
		end
	end

	always @(negedge clk_sys) begin
		if (busy_en) begin
			wait_rng = xorshift32(wait_rng);
			cfg_waitrequest = wait_rng[7];
		end else begin
			cfg_waitrequest = 1'b0;
		end
	end

	// ------------------------------------------------------------------
	// Stimulus
	// ------------------------------------------------------------------

	initial begin
		clk_mgmt_pkg::cpu_speed_t code;
		clk_mgmt_pkg::uart_rate_t rates [3];
		int start_count;
		int cycles;
		rates = '{clk_mgmt_pkg::UART_FAST, clk_mgmt_pkg::UART_MIDI,
			clk_mgmt_pkg::UART_NORMAL};
		repeat (5) @(negedge clk_sys);
		reset = 1'b0;
		// Lock arrives once the filters have settled on the reset requests
		repeat (4) @(negedge clk_sys);
		pll_locked = 1'b1;
		cycles = 0;
		while (seq_count < 1) begin
			@(negedge clk_sys);
			cycles++;
			if (cycles > 40) begin
				$display("Timed out waiting for the sequence after reset");
				abort_run();
			end
		end
		repeat (30) @(negedge clk_sys);
		check_count(test_name, 4, write_count);

		test_name = "random_speed";
		for (int i = 0; i < 6; i++) begin
			rng = xorshift32(rng);
			code = rng[2:0];
			if (code == exp_speed) code = code + 3'd1;
			change_request(code, exp_uart, 20);
		end

		test_name = "uart_rate";
		for (int i = 0; i < 3; i++) begin
			change_request(exp_speed, rates[i], 20);
		end

		test_name = "backpressure";
		busy_en = 1'b1;
		rng = xorshift32(rng);
		code = rng[2:0];
		if (code == exp_speed) code = code + 3'd1;
		fork
			change_request(code, exp_uart, 400);
			begin
				repeat (6) @(negedge clk_sys);
				pll_locked = 1'b0;
				repeat (15) @(negedge clk_sys);
				pll_locked = 1'b1;
			end
		join
		busy_en = 1'b0;

		test_name = "glitch";
		start_count = write_count;
		@(negedge clk_sys);
		speed_req = exp_speed + 3'd1;
		@(negedge clk_sys);
		speed_req = exp_speed;
		repeat (40) @(negedge clk_sys);
		check_count(test_name, start_count, write_count);

		for (int i = 0; i < 2; i++) begin
			code = (i == 0) ? 3'd0 : 3'd4;
			test_name = $sformatf("gameport_code%0d", code);
			if (code != exp_speed) change_request(code, exp_uart, 20);
			else repeat (20) @(negedge clk_sys);
			start_count = toggle_count;
			repeat (20000) @(negedge clk_sys);
			check_toggles(test_name, expected_toggles(code, 20000),
				toggle_count - start_count);
		end

		$display("Simulation finished: PASS");
		$finish;
	end

endmodule

//--- bench/clk_mgmt_chk.sv
// PLL reconfiguration port checks
// Concurrent assertions on the write bundle, bound into the top level

`include "clk_mgmt_defines.svh"

module clk_mgmt_chk (
	input logic                      clk_sys,
	input logic                      reset,
	input logic                      cfg_waitrequest,
	input clk_mgmt_pkg::pll_cfg_wr_t pll_cfg
);

	logic accepted;

	assign accepted = pll_cfg.write && !cfg_waitrequest;

	// Back-pressure freezes address, data and strobe
	hold_under_wait: assert property (@(posedge clk_sys) disable iff (reset)
		cfg_waitrequest |=> $stable(pll_cfg))
		else $error("pll_cfg changed while waitrequest was high");

	// Writes are one-cycle pulses with an idle cycle between them
	no_back_to_back: assert property (@(posedge clk_sys) disable iff (reset)
		accepted |=> !accepted)
		else $error("accepted writes on two consecutive cycles");

	known_address: assert property (@(posedge clk_sys) disable iff (reset)
		pll_cfg.write |-> (pll_cfg.address == `CFG_ADDR_MODE ||
			pll_cfg.address == `CFG_ADDR_START || pll_cfg.address == `CFG_ADDR_CDIV))
		else $error("write to an undefined register address");

	quiet_after_reset: assert property (@(posedge clk_sys)
		$fell(reset) |-> !pll_cfg.write)
		else $error("write asserted in the first cycle after reset");

endmodule

bind clk_mgmt_top clk_mgmt_chk port_chk (
	.clk_sys         (clk_sys),
	.reset           (reset),
	.cfg_waitrequest (cfg_waitrequest),
	.pll_cfg         (pll_cfg)
);

//--- hw/clk_mgmt_top.sv
// Clock management top level
// Filters the CPU speed and UART rate requests, reprograms the PLL
// through its reconfiguration port and derives the gameport clock

module clk_mgmt_top (
	input  logic                      clk_sys,
	input  logic                      reset,
	input  logic                      pll_locked,
	input  logic                      cfg_waitrequest,
	input  clk_mgmt_pkg::cpu_speed_t  speed_req,
	input  clk_mgmt_pkg::uart_rate_t  uart_req,
	output clk_mgmt_pkg::pll_cfg_wr_t pll_cfg,
	output logic                      grav_clk
);

	clk_mgmt_pkg::cpu_speed_t speed_cur;
	clk_mgmt_pkg::uart_rate_t uart_cur;

	// ------------------------------------------------------------------
	// Request filters
	// ------------------------------------------------------------------

	req_filter #(.payload_t(clk_mgmt_pkg::cpu_speed_t)) speed_filter (
		.clk_sys (clk_sys),
		.reset   (reset),
		.req     (speed_req),
		.cur     (speed_cur)
	);

	req_filter #(.payload_t(clk_mgmt_pkg::uart_rate_t)) uart_filter (
		.clk_sys (clk_sys),
		.reset   (reset),
		.req     (uart_req),
		.cur     (uart_cur)
	);

	// ------------------------------------------------------------------
	// PLL reprogramming and gameport clock
	// ------------------------------------------------------------------

	pll_reconfig_fsm sequencer (
		.clk_sys         (clk_sys),
		.reset           (reset),
		.pll_locked      (pll_locked),
		.cfg_waitrequest (cfg_waitrequest),
		.speed_cur       (speed_cur),
		.uart_cur        (uart_cur),
		.pll_cfg         (pll_cfg)
	);

	grav_clock_gen gameport_clk (
		.clk_sys   (clk_sys),
		.reset     (reset),
		.speed_cur (speed_cur),
		.grav_clk  (grav_clk)
	);

endmodule

//--- hw/grav_clock_gen.sv
// Gameport timebase
// Phase accumulator that toggles grav_clk at a fixed average frequency,
// scaled against whatever rate the CPU clock currently runs at

`include "clk_mgmt_defines.svh"

module grav_clock_gen (
	input  logic                     clk_sys,
	input  logic                     reset,
	input  clk_mgmt_pkg::cpu_speed_t speed_cur,
	output logic                     grav_clk
);

	clk_mgmt_pkg::clk_rate_t cur_rate;
	logic [31:0]             acc;
	logic [31:0]             acc_sum;
	logic [31:0]             rate_ext;

	// Current CPU rate, looked up from the filtered speed code
	always_ff @(posedge clk_sys) begin
		cur_rate <= clk_mgmt_pkg::clk_rate_of(speed_cur);
	end

	assign rate_ext = {4'd0, cur_rate};
	assign acc_sum  = acc + `GRAV_STEP;

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			acc      <= 32'd0;
			grav_clk <= 1'b0;
		end else if (acc_sum >= rate_ext) begin
			// Wrap keeps the remainder so the average period stays exact
			acc      <= acc_sum - rate_ext;
			grav_clk <= ~grav_clk;
		end else begin
			acc <= acc_sum;
		end
	end

endmodule

//--- hw/pll_reconfig_fsm.sv
// PLL reconfiguration sequencer
// Writes mode, CPU divider, UART divider and start to the PLL
// reconfiguration port whenever a filtered request changes, and once
// after reset. The port's waitrequest freezes the whole sequencer

`include "clk_mgmt_defines.svh"

module pll_reconfig_fsm (
	input  logic                      clk_sys,
	input  logic                      reset,
	input  logic                      pll_locked,
	input  logic                      cfg_waitrequest,
	input  clk_mgmt_pkg::cpu_speed_t  speed_cur,
	input  clk_mgmt_pkg::uart_rate_t  uart_cur,
	output clk_mgmt_pkg::pll_cfg_wr_t pll_cfg
);

	// Odd states issue a write, even states let it drop again
	localparam logic [2:0] ST_IDLE  = 3'd0;
	localparam logic [2:0] ST_MODE  = 3'd1;
	localparam logic [2:0] ST_SDIV  = 3'd3;
	localparam logic [2:0] ST_UDIV  = 3'd5;
	localparam logic [2:0] ST_START = 3'd7;

	logic [2:0]               state;
	logic                     start_pending;
	clk_mgmt_pkg::cpu_speed_t last_speed;
	clk_mgmt_pkg::uart_rate_t last_uart;
	logic                     changed;
	logic                     advance;

	logic                     cfg_write;
	logic [5:0]               cfg_addr;
	logic [31:0]              cfg_data;

	assign changed = (speed_cur != last_speed) || (uart_cur != last_uart);
	assign advance = !cfg_waitrequest && pll_locked;

	// ------------------------------------------------------------------
	// Control
	// ------------------------------------------------------------------

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			state         <= ST_IDLE;
			cfg_write     <= 1'b0;
			start_pending <= 1'b1;
			last_speed    <= '0;
			last_uart     <= clk_mgmt_pkg::UART_FAST;
		end else if (!cfg_waitrequest) begin
			// A write strobe lasts exactly one accepted cycle
			cfg_write <= 1'b0;
			if (pll_locked) begin
				if (state != ST_IDLE) begin
					state <= state + 3'd1;
				end
				case (state)
					ST_IDLE: begin
						last_speed <= speed_cur;
						last_uart  <= uart_cur;
						if (changed || start_pending) begin
							state         <= ST_MODE;
							start_pending <= 1'b0;
						end
					end
					ST_MODE, ST_SDIV, ST_UDIV, ST_START: begin
						cfg_write <= 1'b1;
					end
					default: begin
						cfg_write <= 1'b0;
					end
				endcase
			end
		end
	end

	// ------------------------------------------------------------------
	// Write address and data
	// ------------------------------------------------------------------

	always_ff @(posedge clk_sys) begin
		if (advance) begin
			case (state)
				ST_MODE: begin
					cfg_addr <= `CFG_ADDR_MODE;
					cfg_data <= 32'd0;
				end
				ST_SDIV: begin
					cfg_addr <= `CFG_ADDR_CDIV;
					cfg_data <= clk_mgmt_pkg::speed_div_of(speed_cur);
				end
				ST_UDIV: begin
					cfg_addr <= `CFG_ADDR_CDIV;
					cfg_data <= clk_mgmt_pkg::uart_div_of(uart_cur);
				end
				ST_START: begin
					cfg_addr <= `CFG_ADDR_START;
					cfg_data <= 32'd0;
				end
				default: begin
					cfg_addr <= cfg_addr;
					cfg_data <= cfg_data;
				end
			endcase
		end
	end

	assign pll_cfg.write   = cfg_write;
	assign pll_cfg.address = cfg_addr;
	assign pll_cfg.data    = cfg_data;

endmodule

//--- hw/req_filter.sv
// Request glitch filter
// Passes a request to the output only once two consecutive samples agree

module req_filter #(
	parameter type payload_t = logic [2:0]
) (
	input  logic     clk_sys,
	input  logic     reset,
	input  payload_t req,
	output payload_t cur
);

	payload_t stage1;
	payload_t stage2;

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			stage1 <= payload_t'(0);
			stage2 <= payload_t'(0);
			cur    <= payload_t'(0);
		end else begin
			stage1 <= req;
			stage2 <= stage1;
			// A single-cycle value never shows in both stages at once
			if (stage2 == stage1) begin
				cur <= stage2;
			end
		end
	end

endmodule

//--- hw/clk_mgmt_pkg.sv
// Clock management types
// Request codes, the PLL configuration write bundle and the table
// lookups that turn a request code into a divider word or a rate

`include "clk_mgmt_defines.svh"

package clk_mgmt_pkg;

	typedef logic [2:0] cpu_speed_t;

	typedef enum logic [1:0] {
		UART_FAST   = 2'd0,
		UART_NORMAL = 2'd1,
		UART_MIDI   = 2'd2
	} uart_rate_t;

	typedef logic [27:0] clk_rate_t;

	// One write on the PLL reconfiguration port
	typedef struct packed {
		logic        write;
		logic [5:0]  address;
		logic [31:0] data;
	} pll_cfg_wr_t;

	function automatic logic [31:0] speed_div_of(input cpu_speed_t code);
		logic [17:0] div;
		case (code)
			3'd0:    div = `SPEED_DIV_0;
			3'd1:    div = `SPEED_DIV_1;
			3'd2:    div = `SPEED_DIV_2;
			3'd3:    div = `SPEED_DIV_3;
			3'd4:    div = `SPEED_DIV_4;
			3'd5:    div = `SPEED_DIV_5;
			3'd6:    div = `SPEED_DIV_6;
			default: div = `SPEED_DIV_7;
		endcase
		return {14'd0, div};
	endfunction

	// Code 3 is not a defined rate and falls back to the MIDI divider
	function automatic logic [31:0] uart_div_of(input uart_rate_t rate);
		case (rate)
			UART_FAST:   return `UART_DIV_FAST;
			UART_NORMAL: return `UART_DIV_NORMAL;
			default:     return `UART_DIV_MIDI;
		endcase
	endfunction

	function automatic clk_rate_t clk_rate_of(input cpu_speed_t code);
		case (code)
			3'd0:    return `CLK_RATE_0;
			3'd1:    return `CLK_RATE_1;
			3'd2:    return `CLK_RATE_2;
			3'd3:    return `CLK_RATE_3;
			3'd4:    return `CLK_RATE_4;
			3'd5:    return `CLK_RATE_5;
			3'd6:    return `CLK_RATE_6;
			default: return `CLK_RATE_7;
		endcase
	endfunction

endpackage

//--- hw/clk_mgmt_defines.svh
// Clock management constants
// PLL reconfiguration register addresses, divider words per CPU speed
// and UART rate, CPU clock rates and the gameport accumulator step

`ifndef CLK_MGMT_DEFINES_SVH
`define CLK_MGMT_DEFINES_SVH

// PLL reconfiguration port registers
`define CFG_ADDR_MODE   6'd0
`define CFG_ADDR_START  6'd2
`define CFG_ADDR_CDIV   6'd5

// Counter-divider word for each CPU speed code
`define SPEED_DIV_0     18'h00505
`define SPEED_DIV_1     18'h01e1e
`define SPEED_DIV_2     18'h00f0f
`define SPEED_DIV_3     18'h00808
`define SPEED_DIV_4     18'h20504
`define SPEED_DIV_5     18'h20504
`define SPEED_DIV_6     18'h20504
`define SPEED_DIV_7     18'h20504

// Resulting CPU clock in Hz, codes 4 to 7 are the overclock setting
`define CLK_RATE_0      28'd90000000
`define CLK_RATE_1      28'd15000000
`define CLK_RATE_2      28'd30000000
`define CLK_RATE_3      28'd56250000
`define CLK_RATE_4      28'd100000000
`define CLK_RATE_5      28'd100000000
`define CLK_RATE_6      28'd100000000
`define CLK_RATE_7      28'd100000000

// UART PLL output divider words
`define UART_DIV_FAST   32'h00040909
`define UART_DIV_NORMAL 32'h0004f4f4
`define UART_DIV_MIDI   32'h00049696

// Gameport timebase step per system clock
`define GRAV_STEP       32'd40000

`endif
